//--- filelist.f
rtl/i2c_ctrl_pkg.sv
rtl/i2c_init_seq.sv
rtl/i2c_cmd_builder.sv
rtl/i2c_cmd_fifo.sv
rtl/i2c_csr_engine.sv
rtl/i2c_ctrl_top.sv
tests/i2c_core_model.sv
tests/tb_i2c_ctrl.sv

//--- rtl/i2c_cmd_builder.sv
/*
 * i2c command builder
 * turns an accepted transfer request into the ordered list of
 * transfer commands, one push per cycle into the command FIFO
 */
module i2c_cmd_builder #(
   parameter int WRITE_BYTES = 2,
   parameter int READ_BYTES  = 2
) (
   input  logic                      iClk,
   input  logic                      rst_n,
   input  logic                      start,
   input  i2c_ctrl_pkg::xfer_req_t   req,
   input  logic [8*WRITE_BYTES-1:0]  tx_data,
   input  logic                      accept,
   output logic                      push,
   output i2c_ctrl_pkg::cmd_item_t   item
);
   import i2c_ctrl_pkg::*;

   localparam int MAX_BYTES = (WRITE_BYTES > READ_BYTES) ? WRITE_BYTES : READ_BYTES;
   localparam int CW        = $clog2(MAX_BYTES + 1);

   typedef enum logic [2:0] {B_IDLE, B_OFFSET, B_DATA, B_RESTART, B_READ} bld_st_e;

   bld_st_e                  st;
   logic [CW-1:0]            cnt;       // bytes emitted in the data phase
   xfer_req_t                req_q;
   logic [8*WRITE_BYTES-1:0] data_q;    // msb byte goes out first
   logic                     take;
   logic                     last_wr;
   logic                     last_rd;

   assign take    = start && accept;
   assign last_wr = (cnt == CW'(WRITE_BYTES - 1));
   assign last_rd = (cnt == CW'(READ_BYTES - 1));

   function automatic cmd_item_t make_item(input logic rd, input logic sta,
                                           input logic sto, input logic [7:0] d);
      cmd_item_t c;
      c.rd    = rd;
      c.start = sta;
      c.stop  = sto;
      c.data  = d;
      return c;
   endfunction

   // ********************
   // sequencing
   // ********************
   always_ff @(posedge iClk)
   begin
      if (!rst_n)
      begin
         st   <= B_IDLE;
         cnt  <= '0;
         push <= 1'b0;
      end
      else
      begin
         case (st)
            B_IDLE:
            begin
               push <= take;   // address item leaves right away
               if (take)
                  st <= B_OFFSET;
            end
            B_OFFSET:
            begin
               push <= 1'b1;
               cnt  <= '0;
               st   <= req_q.rnw ? B_RESTART : B_DATA;
            end
            B_DATA, B_READ:
            begin
               push <= 1'b1;
               cnt  <= cnt + 1'b1;
               if ((st == B_DATA) ? last_wr : last_rd)
                  st <= B_IDLE;
            end
            B_RESTART:
            begin
               push <= 1'b1;
               st   <= B_READ;
            end
            default: st <= B_IDLE;
         endcase
      end
   end

   // item contents and latched request
   always_ff @(posedge iClk)
   begin
      case (st)
         B_IDLE:
            if (take)
            begin
               req_q  <= req;
               data_q <= tx_data;
               item   <= make_item(1'b0, 1'b1, 1'b0, {req.dev_addr, 1'b0});
            end
         B_OFFSET:  item <= make_item(1'b0, 1'b0, 1'b0, req_q.offset);
         B_DATA:
         begin
            item   <= make_item(1'b0, 1'b0, last_wr, data_q[8*WRITE_BYTES-1 -: 8]);
            data_q <= data_q << 8;
         end
         B_RESTART: item <= make_item(1'b0, 1'b1, 1'b0, {req_q.dev_addr, 1'b1});
         B_READ:    item <= make_item(1'b1, 1'b0, last_rd, 8'h00);   // stop on last
         default: ;
      endcase
   end

endmodule

//--- rtl/i2c_cmd_fifo.sv
/*
 * command FIFO
 * circular buffer between builder and CSR engine, head shown on dout
 */
module i2c_cmd_fifo #(
   parameter int DEPTH = 5
) (
   input  logic                    iClk,
   input  logic                    rst_n,
   input  logic                    push,
   input  i2c_ctrl_pkg::cmd_item_t din,
   input  logic                    pop,
   input  logic                    flush,
   output i2c_ctrl_pkg::cmd_item_t dout,
   output logic                    empty
);
   import i2c_ctrl_pkg::*;

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   cmd_item_t     mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          full;

   assign full  = (count == CW'(DEPTH));
   assign empty = (count == '0);
   assign dout  = mem[rd_ptr];

   always_ff @(posedge iClk)
   begin
      if (push)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge iClk)
   begin
      if (!rst_n || flush)   // flush drops everything queued
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge iClk) disable iff (!rst_n) push |-> !full);
   a_no_underflow: assert property (@(posedge iClk) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- rtl/i2c_csr_engine.sv
/*
 * i2c CSR engine
 * forwards the start-up writes, then drains the command FIFO into the
 * core: command write, status polling, rx capture and error recovery
 */
module i2c_csr_engine #(
   parameter int READ_BYTES = 2
) (
   input  logic                    iClk,
   input  logic                    rst_n,
   input  i2c_ctrl_pkg::csr_req_t  init_csr,
   input  logic                    init_done,
   input  logic                    start,
   output logic                    accept,
   input  i2c_ctrl_pkg::cmd_item_t item,
   input  logic                    empty,
   output logic                    pop,
   output logic                    flush,
   output i2c_ctrl_pkg::csr_req_t  csr,
   input  logic [31:0]             csr_readdata,
   input  logic                    irq,
   output logic                    ready,
   output logic                    busy,
   output logic [8*READ_BYTES-1:0] rx_data,
   output logic                    rx_valid,
   output logic                    xfer_done,
   output logic                    xfer_error
);
   import i2c_ctrl_pkg::*;

   localparam int RX_W = 8 * READ_BYTES;

   typedef enum logic [3:0] {
      E_IDLE,
      E_FETCH,     // write next command word
      E_POLL,      // isr read strobe
      E_WAIT,
      E_CHECK,     // isr data valid here
      E_RX_RD,     // rx data read strobe
      E_RX_WAIT,
      E_CAPTURE,
      E_CLEAR      // abort, clear isr
   } eng_st_e;

   eng_st_e  st;
   csr_req_t eng_csr;
   logic     stop_seen;   // stop item already sent
   logic     poll_rx;     // waiting on rx ready instead of tx ready
   logic     rd_byte;
   logic     bus_err;

   // init writes own the port until configuration is finished
   assign csr    = init_done ? eng_csr : init_csr;
   assign accept = init_done && !busy;
   assign ready  = accept;
   assign pop    = (st == E_FETCH) && !empty;
   assign flush  = (st == E_CLEAR);

   assign bus_err = csr_readdata[ISR_NACK] || csr_readdata[ISR_ARBLOST] || irq;

   always_ff @(posedge iClk)
   begin
      if (!rst_n)
      begin
         st            <= E_IDLE;
         eng_csr.write <= 1'b0;
         eng_csr.read  <= 1'b0;
         busy          <= 1'b0;
         stop_seen     <= 1'b0;
         poll_rx       <= 1'b0;
         rx_valid      <= 1'b0;
         xfer_done     <= 1'b0;
         xfer_error    <= 1'b0;
      end
      else
      begin
         // strobes are single cycle
         eng_csr.write <= 1'b0;
         eng_csr.read  <= 1'b0;
         rx_valid      <= 1'b0;
         xfer_done     <= 1'b0;
         xfer_error    <= 1'b0;

         case (st)
            E_IDLE:
               if (start && accept)
               begin
                  busy      <= 1'b1;
                  stop_seen <= 1'b0;
                  st        <= E_FETCH;
               end

            // ********************
            // command issue
            // ********************
            E_FETCH:
               if (!empty)
               begin
                  eng_csr.write <= 1'b1;
                  eng_csr.addr  <= CSR_TFR_CMD;
                  eng_csr.wdata <= {22'd0, item.start, item.stop, item.data};
                  rd_byte       <= item.rd;
                  poll_rx       <= 1'b0;
                  if (item.stop)
                     stop_seen <= 1'b1;
                  st <= E_POLL;
               end
               else if (stop_seen)   // list drained, transfer complete
               begin
                  xfer_done <= 1'b1;
                  busy      <= 1'b0;
                  st        <= E_IDLE;
               end

            E_POLL:
            begin
               eng_csr.read <= 1'b1;
               eng_csr.addr <= CSR_ISR;
               st           <= E_WAIT;
            end

            E_WAIT: st <= E_CHECK;

            E_CHECK:
               if (bus_err)
                  st <= E_CLEAR;
               else if (poll_rx)
                  st <= csr_readdata[ISR_RX_READY] ? E_RX_RD : E_POLL;
               else if (csr_readdata[ISR_TX_READY])
               begin
                  poll_rx <= rd_byte;   // read byte still has to arrive
                  st      <= rd_byte ? E_POLL : E_FETCH;
               end
               else
                  st <= E_POLL;

            // ********************
            // receive path
            // ********************
            E_RX_RD:
            begin
               eng_csr.read <= 1'b1;
               eng_csr.addr <= CSR_RX_DATA;
               st           <= E_RX_WAIT;
            end

            E_RX_WAIT: st <= E_CAPTURE;

            E_CAPTURE:
            begin
               rx_data  <= (rx_data << 8) | RX_W'(csr_readdata[7:0]);   // first byte ends up msb
               rx_valid <= 1'b1;
               st       <= E_FETCH;
            end

            E_CLEAR:
            begin
               eng_csr.write <= 1'b1;
               eng_csr.addr  <= CSR_ISR;
               eng_csr.wdata <= ISR_CLEAR_MASK;
               xfer_done     <= 1'b1;
               xfer_error    <= 1'b1;
               busy          <= 1'b0;
               st            <= E_IDLE;
            end

            default: st <= E_IDLE;
         endcase
      end
   end

   // holds across init and transfer phases of the port
   a_rd_wr_excl: assert property (@(posedge iClk) disable iff (!rst_n)
      !(csr.read && csr.write));

endmodule

//--- rtl/i2c_ctrl_pkg.sv
/*
 * i2c controller shared definitions
 * CSR map and status bits of the I2C master core, the start-up
 * configuration values and the structs passed between blocks
 */
package i2c_ctrl_pkg;

   // ********************
   // CSR map of the core
   // ********************
   typedef enum logic [3:0] {
      CSR_TFR_CMD  = 4'h0,   // transfer command fifo
      CSR_RX_DATA  = 4'h1,   // receive data fifo
      CSR_CTRL     = 4'h2,
      CSR_ISER     = 4'h3,   // interrupt enable
      CSR_ISR      = 4'h4,   // interrupt status, write 1 to clear
      CSR_SCL_LOW  = 4'h8,
      CSR_SCL_HIGH = 4'h9,
      CSR_SDA_HOLD = 4'hA
   } csr_addr_e;

   // isr bit positions
   localparam int ISR_TX_READY = 0;
   localparam int ISR_RX_READY = 1;
   localparam int ISR_NACK     = 2;
   localparam int ISR_ARBLOST  = 3;

   // nack, arblost and rx overflow
   localparam logic [31:0] ISR_CLEAR_MASK = 32'h0000_001C;

   // ********************
   // start-up configuration
   // ********************
   localparam logic [31:0] CFG_CTRL_OFF = 32'h0000_0000;   // core disabled
   localparam logic [31:0] CFG_CTRL_ON  = 32'h0000_0001;   // core enabled
   localparam logic [31:0] CFG_ISER     = 32'h0000_000C;   // nack + arblost irq
   localparam logic [31:0] CFG_SCL_LOW  = 32'd250;
   localparam logic [31:0] CFG_SCL_HIGH = 32'd249;
   localparam logic [31:0] CFG_SDA_HOLD = 32'd126;

   // one access on the csr port
   typedef struct packed {
      logic        write;
      logic        read;
      csr_addr_e   addr;
      logic [31:0] wdata;
   } csr_req_t;

   // one entry of the command list
   typedef struct packed {
      logic       rd;      // read byte, stays inside the controller
      logic       start;   // start or repeated start
      logic       stop;
      logic [7:0] data;
   } cmd_item_t;

   // transfer request from the user side
   typedef struct packed {
      logic       rnw;
      logic [6:0] dev_addr;
      logic [7:0] offset;
   } xfer_req_t;

endpackage

//--- rtl/i2c_ctrl_top.sv
/*
 * i2c master controller top
 * start-up sequencer, command builder, command FIFO and CSR engine
 */
module i2c_ctrl_top #(
   parameter int WRITE_BYTES = 2,
   parameter int READ_BYTES  = 2,
   parameter int INIT_DELAY  = 1024
) (
   input  logic                     iClk,
   input  logic                     rst_n,
   input  logic                     start,
   input  i2c_ctrl_pkg::xfer_req_t  req,
   input  logic [8*WRITE_BYTES-1:0] tx_data,
   input  logic [31:0]              csr_readdata,
   input  logic                     irq,
   output i2c_ctrl_pkg::csr_req_t   csr,
   output logic                     ready,
   output logic                     busy,
   output logic [8*READ_BYTES-1:0]  rx_data,
   output logic                     rx_valid,
   output logic                     xfer_done,
   output logic                     xfer_error
);
   import i2c_ctrl_pkg::*;

   // longest list is 3 + READ_BYTES items
   localparam int FIFO_DEPTH = ((WRITE_BYTES > READ_BYTES) ? WRITE_BYTES : READ_BYTES) + 3;

   csr_req_t  init_csr;
   logic      init_done;
   logic      accept;
   logic      push;
   logic      pop;
   logic      flush;
   logic      empty;
   cmd_item_t bld_item;
   cmd_item_t head_item;

   i2c_init_seq #(.INIT_DELAY(INIT_DELAY)) u_init (
      .iClk(iClk), .rst_n(rst_n), .init_csr(init_csr), .init_done(init_done)
   );

   i2c_cmd_builder #(.WRITE_BYTES(WRITE_BYTES), .READ_BYTES(READ_BYTES)) u_builder (
      .iClk(iClk), .rst_n(rst_n), .start(start), .req(req), .tx_data(tx_data),
      .accept(accept), .push(push), .item(bld_item)
   );

   i2c_cmd_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
      .iClk(iClk), .rst_n(rst_n), .push(push), .din(bld_item), .pop(pop),
      .flush(flush), .dout(head_item), .empty(empty)
   );

   i2c_csr_engine #(.READ_BYTES(READ_BYTES)) u_engine (
      .iClk(iClk), .rst_n(rst_n), .init_csr(init_csr), .init_done(init_done),
      .start(start), .accept(accept), .item(head_item), .empty(empty), .pop(pop),
      .flush(flush), .csr(csr), .csr_readdata(csr_readdata), .irq(irq),
      .ready(ready), .busy(busy), .rx_data(rx_data), .rx_valid(rx_valid),
      .xfer_done(xfer_done), .xfer_error(xfer_error)
   );

endmodule

//--- rtl/i2c_init_seq.sv
/*
 * i2c start-up sequencer
 * waits out a fixed delay after reset, then writes the six
 * configuration registers of the core on consecutive cycles
 */
module i2c_init_seq #(
   parameter int INIT_DELAY = 1024
) (
   input  logic                   iClk,
   input  logic                   rst_n,
   output i2c_ctrl_pkg::csr_req_t init_csr,
   output logic                   init_done
);
   import i2c_ctrl_pkg::*;

   localparam int CW = $clog2(INIT_DELAY + 1);

   typedef enum logic [1:0] {I_DELAY, I_WRITE, I_DONE} init_st_e;

   init_st_e      st;
   logic [CW-1:0] cnt;
   logic [2:0]    idx;   // next configuration entry

   function automatic csr_req_t cfg_write(input logic [2:0] n);
      csr_req_t r;
      r.write = 1'b1;
      r.read  = 1'b0;
      case (n)
         3'd0:    begin r.addr = CSR_CTRL;     r.wdata = CFG_CTRL_OFF; end
         3'd1:    begin r.addr = CSR_ISER;     r.wdata = CFG_ISER;     end
         3'd2:    begin r.addr = CSR_SCL_LOW;  r.wdata = CFG_SCL_LOW;  end
         3'd3:    begin r.addr = CSR_SCL_HIGH; r.wdata = CFG_SCL_HIGH; end
         3'd4:    begin r.addr = CSR_SDA_HOLD; r.wdata = CFG_SDA_HOLD; end
         default: begin r.addr = CSR_CTRL;     r.wdata = CFG_CTRL_ON;  end
      endcase
      return r;
   endfunction

   always_ff @(posedge iClk)
   begin
      if (!rst_n)
      begin
         st             <= I_DELAY;
         cnt            <= '0;
         idx            <= 3'd0;
         init_done      <= 1'b0;
         init_csr.write <= 1'b0;
         init_csr.read  <= 1'b0;
      end
      else
      begin
         case (st)
            I_DELAY:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == CW'(INIT_DELAY - 1))
               begin
                  init_csr <= cfg_write(3'd0);   // disable core first
                  idx      <= 3'd1;
                  st       <= I_WRITE;
               end
            end
            I_WRITE:
            begin
               if (idx == 3'd6)
               begin
                  init_csr.write <= 1'b0;
                  init_done      <= 1'b1;
                  st             <= I_DONE;
               end
               else
               begin
                  init_csr <= cfg_write(idx);
                  idx      <= idx + 1'b1;
               end
            end
            default: ;   // stays configured until reset
         endcase
      end
   end

   // write-only sequence
   a_no_read: assert property (@(posedge iClk) disable iff (!rst_n)
      !init_csr.read);

endmodule

//--- tests/i2c_core_model.sv
/*
 * I2C core model
 * CSR port of the master core with a 256-byte device behind it,
 * logs every CSR write and NACKs one chosen device address
 */
module i2c_core_model #(
   parameter int LOG_DEPTH = 256,
   parameter int DELAY     = 4      // cycles per bus command
) (
   input  logic                   iClk,
   input  logic                   rst_n,
   input  i2c_ctrl_pkg::csr_req_t csr,
   input  logic [6:0]             nack_addr,
   output logic [31:0]            csr_readdata,
   output logic                   irq
);
   timeunit 1ns;
   timeprecision 100ps;
   import i2c_ctrl_pkg::*;

   typedef enum logic [1:0] {P_IDLE, P_OFFSET, P_WRITE, P_READ} phase_e;

   logic [7:0] mem [256];             // device memory
   csr_req_t   wr_log [LOG_DEPTH];
   int         wr_count;

   phase_e     phase;
   logic [7:0] ptr;                   // device address pointer
   logic [7:0] iser;
   logic       tx_ready;
   logic       rx_ready;
   logic       nack;
   logic [7:0] rx_byte;
   logic [7:0] rx_next;
   logic       rd_pend;
   logic       nack_pend;
   int         busy_cnt;

   assign irq = nack && iser[ISR_NACK];

   initial
   begin
      csr_readdata = '0;
      iser         = '0;
      nack         = 1'b0;
      for (int i = 0; i < 256; i++)
         mem[i] = 8'(i * 29 + 8'h5b);   // odd step, distinct per address
   end

   always @(posedge iClk)
   begin
      if (!rst_n)
      begin
         phase        <= P_IDLE;
         iser         <= '0;
         tx_ready     <= 1'b1;
         rx_ready     <= 1'b0;
         nack         <= 1'b0;
         rd_pend      <= 1'b0;
         nack_pend    <= 1'b0;
         busy_cnt     <= 0;
         wr_count     <= 0;
         csr_readdata <= '0;
      end
      else
      begin
         // ********************
         // bus command finishing
         // ********************
         if (busy_cnt > 0)
         begin
            busy_cnt <= busy_cnt - 1;
            if (busy_cnt == 1)
            begin
               tx_ready <= 1'b1;
               if (nack_pend)
                  nack <= 1'b1;
               if (rd_pend)
               begin
                  rx_ready <= 1'b1;
                  rx_byte  <= rx_next;
               end
            end
         end

         if (csr.write)
         begin
            if (wr_count < LOG_DEPTH)
               wr_log[wr_count] <= csr;
            wr_count <= wr_count + 1;
            case (csr.addr)
               CSR_TFR_CMD:
               begin
                  tx_ready  <= 1'b0;
                  busy_cnt  <= DELAY;
                  rd_pend   <= 1'b0;
                  nack_pend <= 1'b0;
                  if (csr.wdata[9])   // start, address byte follows
                  begin
                     nack_pend <= (csr.wdata[7:1] == nack_addr);
                     if (csr.wdata[7:1] == nack_addr)
                        phase <= P_IDLE;
                     else
                        phase <= csr.wdata[0] ? P_READ : P_OFFSET;
                  end
                  else
                     case (phase)
                        P_OFFSET:
                        begin
                           ptr   <= csr.wdata[7:0];
                           phase <= P_WRITE;
                        end
                        P_WRITE:
                        begin
                           mem[ptr] <= csr.wdata[7:0];
                           ptr      <= ptr + 1'b1;
                        end
                        P_READ:
                        begin
                           rd_pend <= 1'b1;
                           rx_next <= mem[ptr];
                           ptr     <= ptr + 1'b1;
                        end
                        default: ;   // after nack, wait for a new start
                     endcase
                  if (csr.wdata[8])
                     phase <= P_IDLE;
               end
               CSR_ISER: iser <= csr.wdata[7:0];
               CSR_ISR:   // write 1 to clear
               begin
                  if (csr.wdata[ISR_NACK])
                     nack <= 1'b0;
               end
               default: ;
            endcase
         end

         if (csr.read)
            case (csr.addr)
               CSR_ISR: csr_readdata <= {28'd0, 1'b0, nack, rx_ready, tx_ready};
               CSR_RX_DATA:
               begin
                  csr_readdata <= {24'd0, rx_byte};
                  rx_ready     <= 1'b0;
               end
               default: csr_readdata <= '0;
            endcase
      end
   end

endmodule

//--- tests/tb_i2c_ctrl.sv
/*
 * testbench for the i2c master controller
 * start-up configuration, burst write and read, NACK abort and
 * start strobes while busy, against a model of the core
 */
module tb_i2c_ctrl;
   timeunit 1ns;
   timeprecision 100ps;
   import i2c_ctrl_pkg::*;

   localparam int         WRITE_BYTES = 2;
   localparam int         READ_BYTES  = 2;
   localparam int         INIT_DELAY  = 100;
   localparam int         MAX_ITEMS   = 3 + WRITE_BYTES + READ_BYTES;
   localparam int         LIMIT       = 2000;    // cycles per wait
   localparam logic [6:0] NACK_DEV    = 7'h5A;

   logic                     iClk;
   logic                     rst_n;
   logic                     start;
   xfer_req_t                req;
   logic [8*WRITE_BYTES-1:0] tx_data;
   logic [31:0]              csr_readdata;
   logic                     irq;
   csr_req_t                 csr;
   logic                     ready;
   logic                     busy;
   logic [8*READ_BYTES-1:0]  rx_data;
   logic                     rx_valid;
   logic                     xfer_done;
   logic                     xfer_error;

   integer    seed;
   int        value_errs;
   int        other_errs;
   bit        aborted;      // a wait timed out, skip the rest
   int        rx_total;
   int        rx_base;
   int        log_base;
   logic      got_error;
   cmd_item_t exp_items [MAX_ITEMS];

   i2c_ctrl_top #(
      .WRITE_BYTES(WRITE_BYTES), .READ_BYTES(READ_BYTES), .INIT_DELAY(INIT_DELAY)
   ) DUT (
      .iClk(iClk), .rst_n(rst_n), .start(start), .req(req), .tx_data(tx_data),
      .csr_readdata(csr_readdata), .irq(irq), .csr(csr), .ready(ready), .busy(busy),
      .rx_data(rx_data), .rx_valid(rx_valid), .xfer_done(xfer_done),
      .xfer_error(xfer_error)
   );

   i2c_core_model core (
      .iClk(iClk), .rst_n(rst_n), .csr(csr), .nack_addr(NACK_DEV),
      .csr_readdata(csr_readdata), .irq(irq)
   );

   initial
   begin
      iClk = 1'b0;
      forever #20 iClk = ~iClk;
   end

   initial
      rx_total = 0;

   always @(posedge iClk)
      if (rx_valid)
         rx_total <= rx_total + 1;   // received byte pulses

   // ********************
   // reference
   // ********************
   function automatic int expected_cmds(input xfer_req_t r, input logic [8*WRITE_BYTES-1:0] d);
      int n;
      exp_items[0] = '{1'b0, 1'b1, 1'b0, {r.dev_addr, 1'b0}};
      exp_items[1] = '{1'b0, 1'b0, 1'b0, r.offset};
      n = 2;
      if (!r.rnw)
         for (int i = 0; i < WRITE_BYTES; i++)
         begin
            exp_items[n] = '{1'b0, 1'b0, (i == WRITE_BYTES - 1), d[8*(WRITE_BYTES-1-i) +: 8]};
            n++;
         end
      else
      begin
         exp_items[2] = '{1'b0, 1'b1, 1'b0, {r.dev_addr, 1'b1}};   // repeated start
         n = 3;
         for (int i = 0; i < READ_BYTES; i++)
         begin
            exp_items[n] = '{1'b1, 1'b0, (i == READ_BYTES - 1), 8'h00};
            n++;
         end
      end
      return n;
   endfunction

   function automatic xfer_req_t random_req(input logic rnw);
      xfer_req_t r;
      r.rnw      = rnw;
      r.dev_addr = 7'($random(seed));
      if (r.dev_addr == NACK_DEV)
         r.dev_addr = ~NACK_DEV;
      r.offset   = 8'($random(seed));
      return r;
   endfunction

   function automatic logic [8*WRITE_BYTES-1:0] random_data();
      logic [8*WRITE_BYTES-1:0] d;
      for (int i = 0; i < WRITE_BYTES; i++)
         d[8*i +: 8] = 8'($random(seed));
      return d;
   endfunction

   // ********************
   // compare tasks
   // ********************
   task automatic check_csr(input string name, input csr_req_t exp, input csr_req_t act);
      if (act !== exp)
      begin
         value_errs++;
         $display("FAIL %s expected wr=%b rd=%b addr=%h data=%h actual wr=%b rd=%b addr=%h data=%h",
                  name, exp.write, exp.read, exp.addr, exp.wdata,
                  act.write, act.read, act.addr, act.wdata);
      end
   endtask

   // read flag never reaches the bus
   task automatic check_cmd(input string name, input cmd_item_t exp, input cmd_item_t act);
      if ({act.start, act.stop, act.data} !== {exp.start, exp.stop, exp.data})
      begin
         value_errs++;
         $display("FAIL %s expected start=%b stop=%b data=%h actual start=%b stop=%b data=%h",
                  name, exp.start, exp.stop, exp.data, act.start, act.stop, act.data);
      end
   endtask

   task automatic check_rx(input string name, input logic [8*READ_BYTES-1:0] exp,
                           input logic [8*READ_BYTES-1:0] act);
      if (act !== exp)
      begin
         value_errs++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bytes(input string name, input logic [8*WRITE_BYTES-1:0] exp,
                              input logic [8*WRITE_BYTES-1:0] act);
      if (act !== exp)
      begin
         value_errs++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_num(input string name, input int exp, input int act);
      if (act != exp)
      begin
         value_errs++;
         $display("FAIL %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   // ********************
   // sequences
   // ********************
   task automatic check_config();
      csr_req_t exp_cfg [6];
      int       n;
      exp_cfg[0] = '{1'b1, 1'b0, CSR_CTRL, CFG_CTRL_OFF};
      exp_cfg[1] = '{1'b1, 1'b0, CSR_ISER, CFG_ISER};
      exp_cfg[2] = '{1'b1, 1'b0, CSR_SCL_LOW, CFG_SCL_LOW};
      exp_cfg[3] = '{1'b1, 1'b0, CSR_SCL_HIGH, CFG_SCL_HIGH};
      exp_cfg[4] = '{1'b1, 1'b0, CSR_SDA_HOLD, CFG_SDA_HOLD};
      exp_cfg[5] = '{1'b1, 1'b0, CSR_CTRL, CFG_CTRL_ON};
      n = 0;
      do
      begin
         @(posedge iClk);
         n++;
      end
      while (!ready && n < INIT_DELAY + LIMIT);
      if (!ready)
      begin
         other_errs++;
         aborted = 1'b1;
         $display("timeout: ready never rose after reset");
         return;
      end
      if (n <= INIT_DELAY)
      begin
         other_errs++;
         $display("ready rose after %0d cycles, before the start-up delay ran out", n);
      end
      check_num("config write count", 6, core.wr_count);
      for (int i = 0; i < 6; i++)
         check_csr($sformatf("config write %0d", i), exp_cfg[i], core.wr_log[i]);
   endtask

   task automatic run_xfer(input xfer_req_t r, input logic [8*WRITE_BYTES-1:0] d, input bit dup);
      int n;
      bit early_idle;   // busy low while the transfer still runs
      if (aborted)
         return;
      log_base = core.wr_count;
      rx_base  = rx_total;
      @(posedge iClk);
      start   <= 1'b1;
      req     <= r;
      tx_data <= d;
      @(posedge iClk);
      start <= 1'b0;
      if (dup)
      begin
         repeat (4) @(posedge iClk);
         start <= 1'b1;   // arrives while busy
         @(posedge iClk);
         start <= 1'b0;
      end
      n          = 0;
      early_idle = 1'b0;
      do
      begin
         @(posedge iClk);
         n++;
         if (!xfer_done && !busy)
            early_idle = 1'b1;
      end
      while (!xfer_done && n < LIMIT);
      if (!xfer_done)
      begin
         other_errs++;
         aborted = 1'b1;
         $display("timeout: no xfer_done within %0d cycles", LIMIT);
         return;
      end
      if (early_idle)
      begin
         other_errs++;
         $display("busy went low before xfer_done");
      end
      got_error = xfer_error;
      @(posedge iClk);   // last write lands in the log
      if (busy)
      begin
         other_errs++;
         $display("busy still high after xfer_done");
      end
   endtask

   task automatic verify_cmds(input string name, input xfer_req_t r,
                              input logic [8*WRITE_BYTES-1:0] d);
      int        n;
      csr_req_t  w;
      cmd_item_t act;
      n = expected_cmds(r, d);
      check_num({name, " command count"}, n, core.wr_count - log_base);
      for (int i = 0; i < n && log_base + i < core.wr_count; i++)
      begin
         w = core.wr_log[log_base + i];
         if (w.addr != CSR_TFR_CMD || w.wdata[31:10] != '0)
         begin
            other_errs++;
            $display("%s: write %0d is not a transfer command word", name, i);
         end
         act = '{1'b0, w.wdata[9], w.wdata[8], w.wdata[7:0]};
         check_cmd($sformatf("%s item %0d", name, i), exp_items[i], act);
      end
   endtask

   initial
   begin
      xfer_req_t                r;
      logic [8*WRITE_BYTES-1:0] d;
      logic [8*WRITE_BYTES-1:0] mem_act;
      logic [8*READ_BYTES-1:0]  exp_rx;
      logic [7:0]               wr_off;
      seed       = 32'h73bad05d;
      value_errs = 0;
      other_errs = 0;
      aborted    = 1'b0;
      rst_n      = 1'b0;
      start      = 1'b0;
      req        = '0;
      tx_data    = '0;
      repeat (16) @(posedge iClk);
      rst_n <= 1'b1;

      check_config();

      // burst write, memory holds tx data msb first
      r      = random_req(1'b0);
      d      = random_data();
      wr_off = r.offset;
      run_xfer(r, d, 1'b0);
      if (!aborted)
      begin
         verify_cmds("write", r, d);
         check_num("write error flag", 0, got_error);
         for (int i = 0; i < WRITE_BYTES; i++)
            mem_act[8*(WRITE_BYTES-1-i) +: 8] = core.mem[8'(wr_off + i)];
         check_bytes("write memory", d, mem_act);
      end

      // burst reads, first one from the written bytes
      for (int k = 0; k < 2; k++)
      begin
         r = random_req(1'b1);
         if (k == 0)
            r.offset = wr_off;
         run_xfer(r, '0, 1'b0);
         if (!aborted)
         begin
            verify_cmds("read", r, '0);
            check_num("read pulses", READ_BYTES, rx_total - rx_base);
            check_num("read error flag", 0, got_error);
            for (int i = 0; i < READ_BYTES; i++)
               exp_rx[8*(READ_BYTES-1-i) +: 8] = core.mem[8'(r.offset + i)];
            check_rx("read data", exp_rx, rx_data);
         end
      end

      // nack abort, then a good transfer
      r          = random_req(1'b0);
      r.dev_addr = NACK_DEV;
      d          = random_data();
      run_xfer(r, d, 1'b0);
      if (!aborted)
      begin
         check_num("nack error flag", 1, got_error);
         check_num("nack write count", 2, core.wr_count - log_base);
         check_csr("nack isr clear", '{1'b1, 1'b0, CSR_ISR, ISR_CLEAR_MASK},
                   core.wr_log[core.wr_count - 1]);
      end
      r = random_req(1'b0);
      d = random_data();
      run_xfer(r, d, 1'b0);
      if (!aborted)
      begin
         verify_cmds("after nack", r, d);
         check_num("after nack error flag", 0, got_error);
      end

      // extra strobe while busy
      r = random_req(1'b0);
      d = random_data();
      run_xfer(r, d, 1'b1);
      if (!aborted)
      begin
         repeat (20) @(posedge iClk);
         verify_cmds("busy strobe", r, d);
      end

      $display("checks finished: %0d value errors, %0d other errors", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
